//--- compile.f
+incdir+test
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/decode_stage.sv
verilog/register_file.sv
verilog/execute_stage.sv
verilog/retire_queue.sv
verilog/core_top.sv
test/tb_core.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the fail message in the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log && \
verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f compile.f -o tb_core && \
./obj_dir/tb_core > sim.log 2>&1 || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

//--- test/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// architectural registers as the model sees them
data_t model_regs [NUM_REGS];

function automatic void clear_model_regs();
  for (int i = 0; i < NUM_REGS; i++) begin
    model_regs[i] = '0;
  end
endfunction

function automatic inst_t build_rtype(funct_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                      shamt_t sh);
  return {OP_RTYPE, rs, rt, rd, sh, fn};
endfunction

function automatic inst_t build_itype(opcode_t op, reg_idx_t rs, reg_idx_t rt, imm_t imm);
  return {op, rs, rt, imm};
endfunction

// runs one instruction in issue order and gives back its retirement pair
function automatic void execute_in_model(input inst_t word, output reg_idx_t dst,
                                         output data_t val);
  data_t a;
  data_t b;
  data_t imm;
  a   = model_regs[word[25:21]];
  b   = model_regs[word[20:16]];
  imm = {16'h0000, word[15:0]};
  if (word[31:26] == OP_RTYPE) begin
    dst = word[15:11];
    case (word[5:0])
      FN_SLL:  val = b << word[10:6];
      FN_ADD:  val = a + b;
      FN_SUB:  val = a - b;
      FN_AND:  val = a & b;
      FN_OR:   val = a | b;
      FN_XOR:  val = a ^ b;
      FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: val = '0;
    endcase
  end else begin
    // immediate ops write rt
    dst = word[20:16];
    case (word[31:26])
      OP_ADDI: val = a + imm;
      OP_ANDI: val = a & imm;
      OP_ORI:  val = a | imm;
      default: val = a ^ imm;
    endcase
  end
  // r0 keeps zero, the pair still retires
  if (dst != '0) begin
    model_regs[dst] = val;
  end
endfunction

`endif

//--- test/tb_core.sv
`timescale 1ns/1ps

module tb_core import isa_pkg::*, core_pkg::*; ();

  logic     clk;
  logic     rst_n;
  logic     inst_valid;
  logic     inst_ready;
  inst_t    inst;
  logic     wb_valid;
  logic     wb_ready;
  reg_idx_t wb_rd;
  data_t    wb_data;

  // stimulus and scoreboard
  inst_t       send_q [$];
  reg_idx_t    exp_rd [$];
  data_t       exp_data [$];
  string       test_name;
  int          test_errors;
  int          error_count;
  int          tests_run;
  int          tests_failed;
  int          test_cycles;
  int          test_limit;
  int          cycle_count;
  int          accepted;
  int          retired;
  int          stall_cycles;
  int          accept_cycle;
  int          retire_cycle;
  bit          random_ready;
  logic [31:0] lfsr_state;

  funct_t  rtype_fns [7] = '{FN_SLL, FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLT};
  opcode_t itype_ops [4] = '{OP_ADDI, OP_ANDI, OP_ORI, OP_XORI};

  `include "core_model.svh"

  core_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst_valid(inst_valid),
    .inst_ready(inst_ready),
    .inst      (inst),
    .wb_valid  (wb_valid),
    .wb_ready  (wb_ready),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  ////////////////////////////////////////
  // random numbers
  ////////////////////////////////////////

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic step_lfsr();
    logic out;
    out        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic logic [31:0] random_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], step_lfsr()};
    end
    return v;
  endfunction

  function automatic reg_idx_t random_reg();
    return reg_idx_t'(random_bits(5));
  endfunction

  function automatic reg_idx_t nonzero_reg();
    reg_idx_t r;
    r = random_reg();
    if (r == '0) begin
      r = 5'd1;
    end
    return r;
  endfunction

  // any legal op, for immediates the destination goes in rt
  function automatic inst_t random_inst(reg_idx_t rs, reg_idx_t rt, reg_idx_t dst);
    int    kind;
    inst_t w;
    kind = int'(random_bits(4)) % 11;
    if (kind < 7) begin
      w = build_rtype(rtype_fns[kind], rs, rt, dst, shamt_t'(random_bits(5)));
    end else begin
      w = build_itype(itype_ops[kind - 7], rs, dst, imm_t'(random_bits(16)));
    end
    return w;
  endfunction

  ////////////////////////////////////////
  // checks and cycle driver
  ////////////////////////////////////////

  task automatic check_reg(string what, reg_idx_t expected, reg_idx_t actual);
    if (expected !== actual) begin
      $display("error %s: %s expected %0d actual %0d", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_data(string what, data_t expected, data_t actual);
    if (expected !== actual) begin
      $display("error %s: %s expected %h actual %h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_flag(string what, logic expected, logic actual);
    if (expected !== actual) begin
      $display("error %s: %s expected %b actual %b", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_count(string what, int expected, int actual);
    if (expected != actual) begin
      $display("error %s: %s expected %0d actual %0d", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  // outputs are settled at the falling edge, transfers land on the next rising one
  task automatic run_cycle();
    reg_idx_t dst;
    data_t    val;
    @(negedge clk);
    cycle_count++;
    test_cycles++;
    wb_ready   = random_ready ? step_lfsr() : 1'b1;
    inst_valid = send_q.size() != 0;
    inst       = inst_valid ? send_q[0] : '0;
    if (inst_valid && !inst_ready) begin
      stall_cycles++;
    end
    if (inst_valid && inst_ready) begin
      execute_in_model(send_q.pop_front(), dst, val);
      exp_rd.push_back(dst);
      exp_data.push_back(val);
      accepted++;
      accept_cycle = cycle_count;
    end
    if (wb_valid && wb_ready) begin
      if (exp_rd.size() == 0) begin
        $display("%s: the core retired an instruction that was never sent", test_name);
        test_errors++;
      end else begin
        check_reg("wb_rd", exp_rd.pop_front(), wb_rd);
        check_data("wb_data", exp_data.pop_front(), wb_data);
      end
      retired++;
      retire_cycle = cycle_count;
    end
  endtask

  task automatic begin_test(string name);
    test_name    = name;
    test_errors  = 0;
    accepted     = 0;
    retired      = 0;
    stall_cycles = 0;
    test_cycles  = 0;
    random_ready = 1'b0;
  endtask

  // send everything queued and wait until the last result is out
  task automatic drain(bit ready_random);
    int sent;
    sent         = send_q.size();
    random_ready = ready_random;
    test_limit   = 20 * sent + 50;
    while (send_q.size() != 0 || exp_rd.size() != 0) begin
      run_cycle();
    end
    // a duplicate retirement would still show up here
    repeat (PIPE_STAGES + 2) run_cycle();
    check_count("retired", sent, retired);
  endtask

  task automatic finish_test();
    tests_run++;
    error_count += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %s done, %0d instructions, %0d errors", test_name, accepted, test_errors);
  endtask

  initial begin : watchdog
    @(negedge clk);
    while (test_cycles <= test_limit) begin
      @(negedge clk);
    end
    $display("timeout in test %s after %0d cycles", test_name, test_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  initial begin
    reg_idx_t prev;
    reg_idx_t prev2;
    reg_idx_t dst;
    lfsr_state   = 32'hcd54;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycle_count  = 0;
    test_cycles  = 0;
    test_limit   = 50;
    rst_n        = 1'b0;
    inst_valid   = 1'b0;
    inst         = '0;
    wb_ready     = 1'b1;
    clear_model_regs();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    begin_test("reset");
    check_flag("wb_valid", 1'b0, wb_valid);
    check_flag("inst_ready", 1'b1, inst_ready);
    for (int r = 0; r < NUM_REGS; r++) begin
      send_q.push_back(build_itype(OP_ORI, reg_idx_t'(r), reg_idx_t'(r), '0));
    end
    drain(1'b0);
    finish_test();

    begin_test("operations");
    // fill every register with a full 32-bit value first
    for (int r = 1; r < NUM_REGS; r++) begin
      send_q.push_back(build_itype(OP_ORI, '0, reg_idx_t'(r), imm_t'(random_bits(16))));
      send_q.push_back(build_rtype(FN_SLL, '0, reg_idx_t'(r), reg_idx_t'(r), 5'd16));
      send_q.push_back(build_itype(OP_XORI, reg_idx_t'(r), reg_idx_t'(r),
                                   imm_t'(random_bits(16))));
    end
    for (int i = 0; i < 150; i++) begin
      prev  = random_reg();
      prev2 = random_reg();
      dst   = random_reg();
      send_q.push_back(random_inst(prev, prev2, dst));
    end
    drain(1'b0);
    finish_test();

    begin_test("dependencies");
    prev  = 5'd1;
    prev2 = 5'd2;
    for (int i = 0; i < 80; i++) begin
      dst = nonzero_reg();
      send_q.push_back(random_inst(prev, prev2, dst));
      prev2 = prev;
      prev  = dst;
    end
    drain(1'b0);
    finish_test();

    begin_test("register_zero");
    for (int i = 0; i < 10; i++) begin
      send_q.push_back(build_itype(OP_ORI, random_reg(), '0, imm_t'(random_bits(16)) | 16'h1));
      send_q.push_back(build_rtype(FN_ADD, '0, '0, nonzero_reg(), '0));
      send_q.push_back(build_itype(OP_XORI, '0, nonzero_reg(), '0));
    end
    drain(1'b0);
    finish_test();

    begin_test("backpressure");
    for (int i = 0; i < 200; i++) begin
      dst   = nonzero_reg();
      prev2 = random_reg();
      send_q.push_back(random_inst(prev, prev2, dst));
      prev = dst;
    end
    drain(1'b1);
    if (stall_cycles == 0) begin
      $display("backpressure: inst_ready never dropped while wb_ready was random");
      test_errors++;
    end
    finish_test();

    begin_test("latency");
    repeat (3) run_cycle();
    send_q.push_back(build_itype(OP_ADDI, random_reg(), nonzero_reg(), imm_t'(random_bits(16))));
    drain(1'b0);
    check_count("wb_valid delay", 3, retire_cycle - accept_cycle);
    finish_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- verilog/core_top.sv
`timescale 1ns/1ps

module core_top import isa_pkg::*, core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     inst_valid,
  output logic     inst_ready,
  input  inst_t    inst,
  output logic     wb_valid,
  input  logic     wb_ready,
  output reg_idx_t wb_rd,
  output data_t    wb_data
);

  logic     advance;
  logic     dec_valid;
  reg_idx_t dec_rs;
  reg_idx_t dec_rt;
  reg_idx_t dec_dst;
  alu_op_e  dec_alu_op;
  logic     dec_use_imm;
  imm_t     dec_imm;
  shamt_t   dec_shamt;
  reg_idx_t rf_raddr_a;
  reg_idx_t rf_raddr_b;
  data_t    rf_rdata_a;
  data_t    rf_rdata_b;
  logic     rf_we;
  reg_idx_t rf_waddr;
  data_t    rf_wdata;
  logic     ex_valid;
  reg_idx_t ex_dst;
  data_t    ex_data;

  // one stall signal for the whole pipe
  assign inst_ready = advance;

  decode_stage u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .advance    (advance),
    .dec_valid  (dec_valid),
    .dec_rs     (dec_rs),
    .dec_rt     (dec_rt),
    .dec_dst    (dec_dst),
    .dec_alu_op (dec_alu_op),
    .dec_use_imm(dec_use_imm),
    .dec_imm    (dec_imm),
    .dec_shamt  (dec_shamt)
  );

  register_file u_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr_a(rf_raddr_a),
    .raddr_b(rf_raddr_b),
    .rdata_a(rf_rdata_a),
    .rdata_b(rf_rdata_b),
    .we     (rf_we),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata)
  );

  execute_stage u_execute (
    .clk        (clk),
    .rst_n      (rst_n),
    .advance    (advance),
    .dec_valid  (dec_valid),
    .dec_rs     (dec_rs),
    .dec_rt     (dec_rt),
    .dec_dst    (dec_dst),
    .dec_alu_op (dec_alu_op),
    .dec_use_imm(dec_use_imm),
    .dec_imm    (dec_imm),
    .dec_shamt  (dec_shamt),
    .rf_raddr_a (rf_raddr_a),
    .rf_raddr_b (rf_raddr_b),
    .rf_rdata_a (rf_rdata_a),
    .rf_rdata_b (rf_rdata_b),
    .rf_we      (rf_we),
    .rf_waddr   (rf_waddr),
    .rf_wdata   (rf_wdata),
    .ex_valid   (ex_valid),
    .ex_dst     (ex_dst),
    .ex_data    (ex_data)
  );

  // the operand stage valid doubles as the push request
  retire_queue u_retire (
    .clk      (clk),
    .rst_n    (rst_n),
    .dec_valid(dec_valid),
    .op_valid (ex_valid),
    .ex_valid (ex_valid),
    .ex_dst   (ex_dst),
    .ex_data  (ex_data),
    .advance  (advance),
    .wb_valid (wb_valid),
    .wb_ready (wb_ready),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

endmodule

//--- verilog/retire_queue.sv
`timescale 1ns/1ps

module retire_queue import core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     dec_valid,
  input  logic     op_valid,
  input  logic     ex_valid,
  input  reg_idx_t ex_dst,
  input  data_t    ex_data,
  output logic     advance,
  output logic     wb_valid,
  input  logic     wb_ready,
  output reg_idx_t wb_rd,
  output data_t    wb_data
);

  reg_idx_t q_dst  [RETIRE_DEPTH];
  data_t    q_data [RETIRE_DEPTH];

  logic [RETIRE_PTR_W-1:0] wr_ptr;
  logic [RETIRE_PTR_W-1:0] rd_ptr;
  logic [RETIRE_CNT_W-1:0] count;
  logic [CREDIT_W-1:0]     credit_need;
  logic                    push;
  logic                    pop;

  ////////////////////////////////////////
  // stall decision
  ////////////////////////////////////////

  // room for everything in flight plus the one about to enter
  assign credit_need = CREDIT_W'(count) + CREDIT_W'(dec_valid) + CREDIT_W'(op_valid)
                     + CREDIT_W'(1);
  assign advance     = credit_need <= CREDIT_W'(RETIRE_DEPTH);

  assign push = ex_valid && advance;
  assign pop  = wb_valid && wb_ready;

  assign wb_valid = count != '0;
  assign wb_rd    = q_dst[rd_ptr];
  assign wb_data  = q_data[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == RETIRE_PTR_W'(RETIRE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == RETIRE_PTR_W'(RETIRE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + RETIRE_CNT_W'(push) - RETIRE_CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_dst[wr_ptr]  <= ex_dst;
      q_data[wr_ptr] <= ex_data;
    end
  end

  // credit check must keep pushes away from a full queue
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid |-> count < RETIRE_CNT_W'(RETIRE_DEPTH));

  // occupancy plus the work still in flight stays within the queue
  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    CREDIT_W'(count) + CREDIT_W'(dec_valid) + CREDIT_W'(op_valid)
      <= CREDIT_W'(RETIRE_DEPTH));

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import isa_pkg::*, core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     advance,
  input  logic     dec_valid,
  input  reg_idx_t dec_rs,
  input  reg_idx_t dec_rt,
  input  reg_idx_t dec_dst,
  input  alu_op_e  dec_alu_op,
  input  logic     dec_use_imm,
  input  imm_t     dec_imm,
  input  shamt_t   dec_shamt,
  output reg_idx_t rf_raddr_a,
  output reg_idx_t rf_raddr_b,
  input  data_t    rf_rdata_a,
  input  data_t    rf_rdata_b,
  output logic     rf_we,
  output reg_idx_t rf_waddr,
  output data_t    rf_wdata,
  output logic     ex_valid,
  output reg_idx_t ex_dst,
  output data_t    ex_data
);

  // operand register
  logic     op_valid;
  reg_idx_t op_rs;
  reg_idx_t op_rt;
  reg_idx_t op_dst;
  alu_op_e  op_alu_op;
  logic     op_use_imm;
  imm_t     op_imm;
  shamt_t   op_shamt;
  data_t    op_a;
  data_t    op_b;

  // most recent result
  logic     last_valid;
  reg_idx_t last_dst;
  data_t    last_data;

  logic     fwd_a;
  logic     fwd_b;
  data_t    src_a;
  data_t    src_b;
  data_t    alu_b;
  data_t    alu_result;

  // read addresses come straight from decode
  assign rf_raddr_a = dec_rs;
  assign rf_raddr_b = dec_rt;

  ////////////////////////////////////////
  // operand register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op_valid <= 1'b0;
    end else if (advance) begin
      op_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      op_rs      <= dec_rs;
      op_rt      <= dec_rt;
      op_dst     <= dec_dst;
      op_alu_op  <= dec_alu_op;
      op_use_imm <= dec_use_imm;
      op_imm     <= dec_imm;
      op_shamt   <= dec_shamt;
      op_a       <= rf_rdata_a;
      op_b       <= rf_rdata_b;
    end
  end

  ////////////////////////////////////////
  // forwarding and alu
  ////////////////////////////////////////

  // the result written on the capture edge missed the register file read
  assign fwd_a = last_valid && last_dst != '0 && last_dst == op_rs;
  assign fwd_b = last_valid && last_dst != '0 && last_dst == op_rt;

  assign src_a = fwd_a ? last_data : op_a;
  assign src_b = fwd_b ? last_data : op_b;

  // immediates are zero extended
  assign alu_b = op_use_imm ? {16'h0000, op_imm} : src_b;

  always_comb begin
    case (op_alu_op)
      ALU_ADD: alu_result = src_a + alu_b;
      ALU_SUB: alu_result = src_a - alu_b;
      ALU_AND: alu_result = src_a & alu_b;
      ALU_OR:  alu_result = src_a | alu_b;
      ALU_XOR: alu_result = src_a ^ alu_b;
      ALU_SLT: alu_result = {31'd0, $signed(src_a) < $signed(alu_b)};
      // shift rt, not rs
      ALU_SLL: alu_result = src_b << op_shamt;
      default: alu_result = src_a + alu_b;
    endcase
  end

  ////////////////////////////////////////
  // register write and retire push
  ////////////////////////////////////////

  assign rf_we    = op_valid && advance;
  assign rf_waddr = op_dst;
  assign rf_wdata = alu_result;

  assign ex_valid = op_valid;
  assign ex_dst   = op_dst;
  assign ex_data  = alu_result;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_valid <= 1'b0;
    end else if (rf_we) begin
      last_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rf_we) begin
      last_dst  <= op_dst;
      last_data <= alu_result;
    end
  end

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ps

module register_file import core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t raddr_a,
  input  reg_idx_t raddr_b,
  output data_t    rdata_a,
  output data_t    rdata_b,
  input  logic     we,
  input  reg_idx_t waddr,
  input  data_t    wdata
);

  data_t regs [NUM_REGS];

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      // register 0 never takes a write
      regs[waddr] <= wdata;
    end
  end

  ////////////////////////////////////////
  // read ports
  ////////////////////////////////////////

  // same-edge writes are not bypassed here, the execute stage forwards them
  assign rdata_a = regs[raddr_a];
  assign rdata_b = regs[raddr_b];

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import isa_pkg::*, core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     inst_valid,
  input  inst_t    inst,
  input  logic     advance,
  output logic     dec_valid,
  output reg_idx_t dec_rs,
  output reg_idx_t dec_rt,
  output reg_idx_t dec_dst,
  output alu_op_e  dec_alu_op,
  output logic     dec_use_imm,
  output imm_t     dec_imm,
  output shamt_t   dec_shamt
);

  opcode_t  opcode;
  funct_t   funct;
  reg_idx_t rd;
  reg_idx_t rt;
  alu_op_e  alu_op_n;
  logic     use_imm_n;
  logic     op_legal;

  assign opcode = inst[OPCODE_LSB +: $bits(opcode_t)];
  assign funct  = inst[FUNCT_LSB +: $bits(funct_t)];
  assign rd     = inst[RD_LSB +: REG_FIELD_W];
  assign rt     = inst[RT_LSB +: REG_FIELD_W];

  ////////////////////////////////////////
  // control decode
  ////////////////////////////////////////

  always_comb begin
    alu_op_n  = ALU_ADD;
    use_imm_n = 1'b1;
    op_legal  = 1'b1;
    case (opcode)
      OP_RTYPE: begin
        use_imm_n = 1'b0;
        case (funct)
          FN_SLL:  alu_op_n = ALU_SLL;
          FN_ADD:  alu_op_n = ALU_ADD;
          FN_SUB:  alu_op_n = ALU_SUB;
          FN_AND:  alu_op_n = ALU_AND;
          FN_OR:   alu_op_n = ALU_OR;
          FN_XOR:  alu_op_n = ALU_XOR;
          FN_SLT:  alu_op_n = ALU_SLT;
          default: op_legal = 1'b0;
        endcase
      end
      OP_ADDI: alu_op_n = ALU_ADD;
      OP_ANDI: alu_op_n = ALU_AND;
      OP_ORI:  alu_op_n = ALU_OR;
      OP_XORI: alu_op_n = ALU_XOR;
      default: op_legal = 1'b0;
    endcase
  end

  // accept whenever the pipe moves
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else if (advance) begin
      dec_valid <= inst_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      dec_rs      <= inst[RS_LSB +: REG_FIELD_W];
      dec_rt      <= rt;
      // rd for register ops, rt for immediate ops
      dec_dst     <= use_imm_n ? rt : rd;
      dec_alu_op  <= alu_op_n;
      dec_use_imm <= use_imm_n;
      dec_imm     <= inst[IMM_LSB +: $bits(imm_t)];
      dec_shamt   <= inst[SHAMT_LSB +: $bits(shamt_t)];
    end
  end

  // only the listed encodings may enter the pipe
  a_legal_inst: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid && advance |-> op_legal);

  // a waiting word holds still until it is taken
  a_inst_stable: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid && !advance |=> inst_valid && $stable(inst));

endmodule

//--- verilog/core_pkg.sv
package core_pkg;

  // datapath values
  typedef logic [31:0] data_t;
  typedef logic [4:0]  reg_idx_t;

  // alu operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL
  } alu_op_e;

  localparam int NUM_REGS = 32;

  // retirement queue sizing
  localparam int RETIRE_DEPTH = 4;
  localparam int RETIRE_PTR_W = $clog2(RETIRE_DEPTH);
  localparam int RETIRE_CNT_W = $clog2(RETIRE_DEPTH + 1);

  // decode and operand stages may each hold one instruction
  localparam int PIPE_STAGES = 2;

  // wide enough for occupancy plus every stage plus the new one
  localparam int CREDIT_W = $clog2(RETIRE_DEPTH + PIPE_STAGES + 2);

endpackage

//--- verilog/isa_pkg.sv
package isa_pkg;

  // instruction word and its fields
  typedef logic [31:0] inst_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [15:0] imm_t;
  typedef logic [4:0]  shamt_t;

  // field positions inside the word
  localparam int OPCODE_LSB  = 26;
  localparam int RS_LSB      = 21;
  localparam int RT_LSB      = 16;
  localparam int RD_LSB      = 11;
  localparam int SHAMT_LSB   = 6;
  localparam int FUNCT_LSB   = 0;
  localparam int IMM_LSB     = 0;
  localparam int REG_FIELD_W = 5;

  // opcodes
  localparam opcode_t OP_RTYPE = 6'd0;
  localparam opcode_t OP_ADDI  = 6'd8;
  localparam opcode_t OP_ANDI  = 6'd12;
  localparam opcode_t OP_ORI   = 6'd13;
  localparam opcode_t OP_XORI  = 6'd14;

  // function codes, only meaningful with OP_RTYPE
  localparam funct_t FN_SLL = 6'd0;
  localparam funct_t FN_ADD = 6'd32;
  localparam funct_t FN_SUB = 6'd34;
  localparam funct_t FN_AND = 6'd36;
  localparam funct_t FN_OR  = 6'd37;
  localparam funct_t FN_XOR = 6'd38;
  localparam funct_t FN_SLT = 6'd42;

endpackage
